// ==== src/mem_stage_pkg.sv ====
`default_nettype none

package mem_stage_pkg;

    localparam int data_w = 32;   // memory word and operand width
    localparam int lit_w = 6;     // literal field of an operand selector

    typedef enum logic [1:0] {
        size_byte  = 2'd0,
        size_word  = 2'd1,
        size_dword = 2'd2
    } opsize_t;

    // the fourth kind code is left undefined and decodes to zero
    typedef enum logic [1:0] {
        kind_reg = 2'd0,
        kind_mem = 2'd1,
        kind_imm = 2'd2
    } op_kind_t;

    // register form: slot 3 is the kind, slots 2 and 1 are unused, slot 0 is the index
    // literal form: bits 7 and 6 are the kind, bits 5 to 0 are the literal
    typedef union packed {
        logic [3:0][1:0] reg_form;
        logic [7:0]      imm_form;
    } op_sel_u;

    function automatic op_kind_t sel_kind(input op_sel_u sel);
        return op_kind_t'(sel.reg_form[3]);   // same two bits in both forms
    endfunction

    function automatic logic [data_w-1:0] sel_literal(input op_sel_u sel);
        return data_w'(sel.imm_form[lit_w-1:0]);   // zero extended
    endfunction

    function automatic logic [2:0] size_step(input opsize_t size);
        logic [2:0] step;
        case (size)
            size_byte:  step = 3'd1;
            size_word:  step = 3'd2;
            size_dword: step = 3'd4;
            default:    step = 3'd4;   // treat the unused code as a dword
        endcase
        return step;
    endfunction

endpackage

`default_nettype wire

// ==== src/mem_req_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface mem_req_if
    import mem_stage_pkg::*;
#(
    parameter int ADDR_W = 16
) ();

    logic              req_valid;
    logic [ADDR_W-1:0] req_addr;    // byte address of the read
    logic [ADDR_W-1:0] req_tag;     // destination address, returned unchanged
    logic              busy;
    logic              resp_valid;
    logic [data_w-1:0] resp_data;
    logic [ADDR_W-1:0] resp_tag;

    modport walker (
        output req_valid, req_addr, req_tag,
        input  busy, resp_valid
    );

    modport cache (
        input  req_valid, req_addr, req_tag,
        output busy, resp_valid, resp_data, resp_tag
    );

endinterface

`default_nettype wire

// ==== src/rep_walker.sv ====
`timescale 1ns/10ps
`default_nettype none

module rep_walker
    import mem_stage_pkg::*;
#(
    parameter int ADDR_W = 16
) (
    input  wire logic              clk_i,
    input  wire logic              rst_n_i,
    input  wire logic              valid_i,
    input  wire logic              is_rep_i,
    input  wire logic              dir_dec_i,
    input  wire opsize_t           size_i,
    input  wire logic [15:0]       count_i,
    input  wire logic [ADDR_W-1:0] addr1_i,
    input  wire logic [ADDR_W-1:0] addr2_i,
    input  wire op_sel_u           op1_sel_i,
    input  wire op_sel_u           op2_sel_i,
    mem_req_if.walker              mem,
    output logic                   stall_o,
    output op_sel_u                op1_sel_o,
    output op_sel_u                op2_sel_o
);

    logic [15:0]       cnt_q;
    logic [ADDR_W-1:0] src_q;
    logic [ADDR_W-1:0] dst_q;
    logic [2:0]        step_q;
    logic              dec_q;
    logic              start;
    logic              accept;
    logic [ADDR_W-1:0] delta;

    assign start  = valid_i && !stall_o;             // new instruction only while idle
    assign accept = mem.req_valid && !mem.busy;
    assign delta  = ADDR_W'(step_q);

    // the instruction stays in the stage until every read has been answered
    assign stall_o = (cnt_q != 16'd0) || mem.busy || mem.resp_valid;

    assign mem.req_valid = cnt_q != 16'd0;
    assign mem.req_addr  = src_q;
    assign mem.req_tag   = dst_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q <= 16'd0;
        end else if (start) begin
            cnt_q <= is_rep_i ? count_i : 16'd1;   // a plain read is one iteration
        end else if (accept) begin
            cnt_q <= cnt_q - 16'd1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (start) begin
            src_q     <= addr1_i;
            dst_q     <= addr2_i;
            step_q    <= size_step(size_i);
            dec_q     <= dir_dec_i;
            op1_sel_o <= op1_sel_i;
            op2_sel_o <= op2_sel_i;
        end else if (accept) begin
            src_q <= dec_q ? src_q - delta : src_q + delta;
            dst_q <= dec_q ? dst_q - delta : dst_q + delta;
        end
    end

endmodule

`default_nettype wire

// ==== src/dcache_lite.sv ====
`timescale 1ns/10ps
`default_nettype none

module dcache_lite
    import mem_stage_pkg::*;
#(
    parameter int ADDR_W = 16,
    parameter int LINES  = 8
) (
    input  wire logic              clk_i,
    input  wire logic              rst_n_i,
    mem_req_if.cache               mem,
    output logic                   fill_req_o,
    output logic [ADDR_W-1:0]      fill_addr_o,
    input  wire logic              fill_valid_i,
    input  wire logic [data_w-1:0] fill_data_i
);

    localparam int WORD_W = ADDR_W - 2;        // 32-bit word address
    localparam int IDX_W  = $clog2(LINES);
    localparam int TAG_W  = WORD_W - IDX_W;

    logic [data_w-1:0] data_mem [LINES];
    logic [TAG_W-1:0]  tag_mem  [LINES];
    logic [LINES-1:0]  valid_q;

    logic              busy_q;
    logic              fill_req_q;
    logic              resp_valid_q;
    logic [data_w-1:0] resp_data_q;
    logic [ADDR_W-1:0] resp_tag_q;
    logic [WORD_W-1:0] miss_word_q;
    logic [ADDR_W-1:0] miss_tag_q;

    logic [WORD_W-1:0] req_word;
    logic [IDX_W-1:0]  req_idx;
    logic [TAG_W-1:0]  req_line_tag;
    logic [IDX_W-1:0]  miss_idx;
    logic [TAG_W-1:0]  miss_line_tag;
    logic              accept;
    logic              hit;
    logic              fill_done;

    assign req_word      = mem.req_addr[ADDR_W-1:2];
    assign req_idx       = req_word[IDX_W-1:0];
    assign req_line_tag  = req_word[WORD_W-1:IDX_W];
    assign miss_idx      = miss_word_q[IDX_W-1:0];
    assign miss_line_tag = miss_word_q[WORD_W-1:IDX_W];

    assign accept    = mem.req_valid && !busy_q;
    assign hit       = valid_q[req_idx] && (tag_mem[req_idx] == req_line_tag);
    assign fill_done = busy_q && fill_valid_i;   // only one fill is ever outstanding

    assign mem.busy       = busy_q;
    assign mem.resp_valid = resp_valid_q;
    assign mem.resp_data  = resp_data_q;
    assign mem.resp_tag   = resp_tag_q;

    assign fill_req_o  = fill_req_q;
    assign fill_addr_o = {miss_word_q, 2'b00};

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q      <= '0;
            busy_q       <= 1'b0;
            fill_req_q   <= 1'b0;
            resp_valid_q <= 1'b0;
        end else begin
            fill_req_q   <= accept && !hit;   // single cycle pulse per miss
            resp_valid_q <= (accept && hit) || fill_done;
            if (accept && !hit) begin
                busy_q <= 1'b1;
            end else if (fill_done) begin
                busy_q <= 1'b0;
            end
            if (fill_done) begin
                valid_q[miss_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept && !hit) begin
            miss_word_q <= req_word;
            miss_tag_q  <= mem.req_tag;
        end
        if (accept && hit) begin
            resp_data_q <= data_mem[req_idx];
            resp_tag_q  <= mem.req_tag;
        end else if (fill_done) begin
            resp_data_q        <= fill_data_i;   // answer straight from the fill
            resp_tag_q         <= miss_tag_q;
            data_mem[miss_idx] <= fill_data_i;
            tag_mem[miss_idx]  <= miss_line_tag;
        end
    end

endmodule

`default_nettype wire

// ==== src/opswap.sv ====
`timescale 1ns/10ps
`default_nettype none

module opswap
    import mem_stage_pkg::*;
#(
    parameter int ADDR_W = 16
) (
    input  wire logic              clk_i,
    input  wire logic              rst_n_i,
    input  wire op_sel_u           op1_sel_i,
    input  wire op_sel_u           op2_sel_i,
    input  wire logic [data_w-1:0] reg0_i,
    input  wire logic [data_w-1:0] reg1_i,
    input  wire logic [data_w-1:0] reg2_i,
    input  wire logic [data_w-1:0] reg3_i,
    input  wire logic              mem_valid_i,
    input  wire logic [data_w-1:0] mem_data_i,
    input  wire logic [ADDR_W-1:0] mem_tag_i,
    output logic                   valid_o,
    output logic [data_w-1:0]      op1_o,
    output logic [data_w-1:0]      op2_o,
    output logic [ADDR_W-1:0]      dest_addr_o
);

    logic [3:0][data_w-1:0] reg_file;
    logic [data_w-1:0]      op1_next;
    logic [data_w-1:0]      op2_next;

    function automatic logic [data_w-1:0] pick_operand(
        input op_sel_u                sel,
        input logic [3:0][data_w-1:0] regs,
        input logic [data_w-1:0]      mem_word
    );
        logic [data_w-1:0] val;
        case (sel_kind(sel))
            kind_reg: val = regs[sel.reg_form[0]];
            kind_mem: val = mem_word;
            kind_imm: val = sel_literal(sel);
            default:  val = '0;   // kind 3 has no source
        endcase
        return val;
    endfunction

    assign reg_file = {reg3_i, reg2_i, reg1_i, reg0_i};
    assign op1_next = pick_operand(op1_sel_i, reg_file, mem_data_i);
    assign op2_next = pick_operand(op2_sel_i, reg_file, mem_data_i);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= mem_valid_i;   // one result per memory response
        end
    end

    always_ff @(posedge clk_i) begin
        if (mem_valid_i) begin
            op1_o       <= op1_next;
            op2_o       <= op2_next;
            dest_addr_o <= mem_tag_i;
        end
    end

endmodule

`default_nettype wire

// ==== src/mem_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_stage
    import mem_stage_pkg::*;
#(
    parameter int ADDR_W = 16,
    parameter int LINES  = 8
) (
    input  wire logic              clk_i,
    input  wire logic              rst_n_i,
    input  wire logic              valid_i,
    input  wire logic              is_rep_i,
    input  wire logic              dir_dec_i,
    input  wire opsize_t           size_i,
    input  wire logic [15:0]       count_i,
    input  wire logic [ADDR_W-1:0] addr1_i,
    input  wire logic [ADDR_W-1:0] addr2_i,
    input  wire op_sel_u           op1_sel_i,
    input  wire op_sel_u           op2_sel_i,
    input  wire logic [data_w-1:0] reg0_i,
    input  wire logic [data_w-1:0] reg1_i,
    input  wire logic [data_w-1:0] reg2_i,
    input  wire logic [data_w-1:0] reg3_i,
    input  wire logic              fill_valid_i,
    input  wire logic [data_w-1:0] fill_data_i,
    output logic                   stall_o,
    output logic                   valid_o,
    output logic [data_w-1:0]      op1_o,
    output logic [data_w-1:0]      op2_o,
    output logic [ADDR_W-1:0]      dest_addr_o,
    output logic                   fill_req_o,
    output logic [ADDR_W-1:0]      fill_addr_o
);

    mem_req_if #(.ADDR_W(ADDR_W)) req_bus ();

    op_sel_u op1_sel;   // held by the walker for the whole instruction
    op_sel_u op2_sel;

    rep_walker #(.ADDR_W(ADDR_W)) u_walker (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .valid_i   (valid_i),
        .is_rep_i  (is_rep_i),
        .dir_dec_i (dir_dec_i),
        .size_i    (size_i),
        .count_i   (count_i),
        .addr1_i   (addr1_i),
        .addr2_i   (addr2_i),
        .op1_sel_i (op1_sel_i),
        .op2_sel_i (op2_sel_i),
        .mem       (req_bus),
        .stall_o   (stall_o),
        .op1_sel_o (op1_sel),
        .op2_sel_o (op2_sel)
    );

    dcache_lite #(.ADDR_W(ADDR_W), .LINES(LINES)) u_dcache (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .mem          (req_bus),
        .fill_req_o   (fill_req_o),
        .fill_addr_o  (fill_addr_o),
        .fill_valid_i (fill_valid_i),
        .fill_data_i  (fill_data_i)
    );

    opswap #(.ADDR_W(ADDR_W)) u_opswap (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .op1_sel_i   (op1_sel),
        .op2_sel_i   (op2_sel),
        .reg0_i      (reg0_i),
        .reg1_i      (reg1_i),
        .reg2_i      (reg2_i),
        .reg3_i      (reg3_i),
        .mem_valid_i (req_bus.resp_valid),
        .mem_data_i  (req_bus.resp_data),
        .mem_tag_i   (req_bus.resp_tag),
        .valid_o     (valid_o),
        .op1_o       (op1_o),
        .op2_o       (op2_o),
        .dest_addr_o (dest_addr_o)
    );

endmodule

`default_nettype wire

// ==== test/mem_stage_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_stage_assertions (
    input wire logic clk_i,
    input wire logic rst_n_i,
    input wire logic valid_i,
    input wire logic stall_o,
    input wire logic fill_req_o,
    input wire logic fill_valid_i,
    input wire logic valid_o
);

    logic fill_pending;   // a fill has been requested and not yet returned

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fill_pending <= 1'b0;
        end else if (fill_req_o) begin
            fill_pending <= 1'b1;
        end else if (fill_valid_i) begin
            fill_pending <= 1'b0;
        end
    end

    no_issue_in_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(valid_i && stall_o)) else $error("valid_i high while stall_o is high");

    fill_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fill_req_o |=> !fill_req_o) else $error("fill_req_o longer than one cycle");

    single_fill: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fill_pending |-> !fill_req_o) else $error("second fill_req_o before fill_valid_i");

    idle_after_reset: assert property (@(posedge clk_i)
        $rose(rst_n_i) |-> !valid_o) else $error("valid_o high right after reset");

endmodule

`default_nettype wire

// ==== test/tb_mem_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_mem_stage
    import mem_stage_pkg::*;
();

    localparam int ADDR_W = 16;

    logic              clk;
    logic              rst_n;
    logic              valid, is_rep, dir_dec, fill_valid;
    opsize_t           size;
    logic [15:0]       count;
    logic [ADDR_W-1:0] addr1, addr2, dest_addr, fill_addr;
    op_sel_u           op1_sel, op2_sel;
    logic [data_w-1:0] regs [4];
    logic [data_w-1:0] fill_data, op1, op2;
    logic              stall, out_valid, fill_req;
    logic [16:0]       lfsr = 17'd73045;
    int                errors = 0;
    int                tests = 0;
    int                failed_tests = 0;
    logic [data_w-1:0] got_op1 [$];
    logic [data_w-1:0] got_op2 [$];
    logic [ADDR_W-1:0] got_dest [$];
    logic [ADDR_W-1:0] fill_log [$];   // fill addresses seen during the current instruction

    mem_stage #(.ADDR_W(ADDR_W), .LINES(8)) DUT (
        .clk_i(clk), .rst_n_i(rst_n), .valid_i(valid), .is_rep_i(is_rep),
        .dir_dec_i(dir_dec), .size_i(size), .count_i(count),
        .addr1_i(addr1), .addr2_i(addr2), .op1_sel_i(op1_sel), .op2_sel_i(op2_sel),
        .reg0_i(regs[0]), .reg1_i(regs[1]), .reg2_i(regs[2]), .reg3_i(regs[3]),
        .fill_valid_i(fill_valid), .fill_data_i(fill_data),
        .stall_o(stall), .valid_o(out_valid), .op1_o(op1), .op2_o(op2),
        .dest_addr_o(dest_addr), .fill_req_o(fill_req), .fill_addr_o(fill_addr)
    );

    bind mem_stage mem_stage_assertions u_assertions (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr[16] ^ lfsr[13];   // taps for x^17 + x^14 + 1
        lfsr = {lfsr[15:0], fb};
        return fb;
    endfunction

    function automatic logic [data_w-1:0] model_word(input logic [ADDR_W-1:0] addr);
        return data_w'(addr[ADDR_W-1:2]) ^ 32'h5A5A_0000;
    endfunction

    function automatic op_sel_u reg_sel(input logic [1:0] idx);
        op_sel_u s;
        s.imm_form = '0;
        s.reg_form[3] = kind_reg;
        s.reg_form[0] = idx;
        return s;
    endfunction

    function automatic op_sel_u imm_sel(input logic [5:0] lit);
        op_sel_u s;
        s.imm_form = {kind_imm, lit};
        return s;
    endfunction

    function automatic op_sel_u mem_sel();
        op_sel_u s;
        s.imm_form = {kind_mem, 6'd0};
        return s;
    endfunction

    task automatic check_word(input string name, input logic [data_w-1:0] got, exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input logic [ADDR_W-1:0] got, exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, exp);
        if (got != exp) begin
            errors++;
            $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // the outside memory answers each fill after a random delay of 1 to 6 cycles
    initial begin : memory_model
        logic [ADDR_W-1:0] addr;
        int                delay;
        fill_valid = 1'b0;
        fill_data  = '0;
        forever begin
            @(posedge clk);
            #1;
            if (fill_req) begin
                addr = fill_addr;
                fill_log.push_back(addr);
                delay = 1 + int'({lfsr_bit(), lfsr_bit(), lfsr_bit()}) % 6;
                repeat (delay) @(posedge clk);
                #1;
                fill_valid = 1'b1;
                fill_data  = model_word(addr);
                @(posedge clk);
                #1;
                fill_valid = 1'b0;
            end
        end
    end

    // issue one instruction and gather every result until the stage goes idle
    task automatic run_instr(input logic rep, dec, input opsize_t sz, input logic [15:0] cnt,
                             input logic [ADDR_W-1:0] a1, a2, input op_sel_u s1, s2);
        int cycles;
        got_op1.delete();
        got_op2.delete();
        got_dest.delete();
        fill_log.delete();
        valid = 1'b1;
        is_rep = rep;
        dir_dec = dec;
        size = sz;
        count = cnt;
        addr1 = a1;
        addr2 = a2;
        op1_sel = s1;
        op2_sel = s2;
        @(posedge clk);
        #1;
        valid = 1'b0;
        cycles = 0;
        while (stall && cycles < 200) begin
            if (out_valid) begin
                got_op1.push_back(op1);
                got_op2.push_back(op2);
                got_dest.push_back(dest_addr);
            end
            @(posedge clk);
            #1;
            cycles++;
        end
        if (stall) begin
            errors++;
            $display("timeout: stall_o stayed high for %0d cycles", cycles);
        end else if (out_valid) begin   // the last result shows in the cycle stall drops
            got_op1.push_back(op1);
            got_op2.push_back(op2);
            got_dest.push_back(dest_addr);
        end
    endtask

    // results of a walk, with one fill per new word address when the lines are cold
    task automatic check_walk(input int n, input logic [ADDR_W-1:0] a1, a2, input int step,
                              input logic cold);
        logic [ADDR_W-1:0] src;
        logic [ADDR_W-1:0] prev;
        logic [ADDR_W-1:0] words [$];
        prev = '0;
        for (int k = 0; k < n; k++) begin
            src = a1 + ADDR_W'(step * k);
            if (k == 0 || src[ADDR_W-1:2] != prev[ADDR_W-1:2]) begin
                words.push_back({src[ADDR_W-1:2], 2'b00});
            end
            prev = src;
            if (k < got_op1.size()) begin
                check_addr("dest_addr_o", got_dest[k], a2 + ADDR_W'(step * k));
                check_word("op1_o", got_op1[k], model_word(src));
            end
        end
        check_count("valid_o count", got_op1.size(), n);
        if (!cold) words.delete();
        check_count("fill_req_o count", fill_log.size(), words.size());
        foreach (fill_log[i]) begin
            if (i < words.size()) check_addr("fill_addr_o", fill_log[i], words[i]);
        end
        @(posedge clk);
        #1;
        check_bit("stall_o", stall, 1'b0);       // the stage stays idle after the walk
        check_bit("valid_o", out_valid, 1'b0);
    endtask

    task automatic operand_case(input op_sel_u s1, s2, input logic [data_w-1:0] e1, e2);
        run_instr(1'b0, 1'b0, size_dword, 16'd0, 16'h1236, 16'h4100, s1, s2);
        check_count("valid_o count", got_op1.size(), 1);
        if (got_op1.size() == 1) begin
            check_word("op1_o", got_op1[0], e1);
            check_word("op2_o", got_op2[0], e2);
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests++;
        if (errors != errs_before) failed_tests++;
        $display("test %-14s %s", name, (errors == errs_before) ? "ok" : "FAILED");
    endtask

    task automatic reset_state();
        int e;
        e = errors;
        check_bit("stall_o", stall, 1'b0);
        check_bit("valid_o", out_valid, 1'b0);
        check_bit("fill_req_o", fill_req, 1'b0);
        finish_test("reset_state", e);
    endtask

    task automatic cold_read();
        int e;
        e = errors;
        run_instr(1'b0, 1'b0, size_dword, 16'd9, 16'h1236, 16'h4000, mem_sel(), imm_sel(6'd0));
        check_walk(1, 16'h1236, 16'h4000, 4, 1'b1);
        run_instr(1'b0, 1'b0, size_dword, 16'd9, 16'h1236, 16'h4000, mem_sel(), imm_sel(6'd0));
        check_walk(1, 16'h1236, 16'h4000, 4, 1'b0);   // now a hit
        finish_test("cold_read", e);
    endtask

    task automatic rep_up();
        int e;
        e = errors;
        run_instr(1'b1, 1'b0, size_dword, 16'd5, 16'h2000, 16'h5000, mem_sel(), reg_sel(2'd0));
        check_walk(5, 16'h2000, 16'h5000, 4, 1'b1);
        finish_test("rep_up_dword", e);
    endtask

    task automatic rep_down();
        int e;
        e = errors;
        run_instr(1'b1, 1'b1, size_byte, 16'd6, 16'h3003, 16'h6010, mem_sel(), reg_sel(2'd0));
        check_walk(6, 16'h3003, 16'h6010, -1, 1'b1);
        finish_test("rep_down_byte", e);
    endtask

    task automatic rep_zero();
        int e;
        e = errors;
        run_instr(1'b1, 1'b0, size_dword, 16'd0, 16'h2800, 16'h5800, mem_sel(), reg_sel(2'd0));
        check_walk(0, 16'h2800, 16'h5800, 4, 1'b1);
        finish_test("rep_zero", e);
    endtask

    task automatic operand_forms();
        int e;
        e = errors;
        regs[0] = 32'h0000_A000;
        regs[1] = 32'h1111_B001;
        regs[2] = 32'h2222_C002;
        regs[3] = 32'h3333_D003;
        operand_case(reg_sel(2'd2), imm_sel(6'h2B), 32'h2222_C002, 32'h0000_002B);
        operand_case(mem_sel(), reg_sel(2'd1), model_word(16'h1234), 32'h1111_B001);
        operand_case(imm_sel(6'h3F), reg_sel(2'd3), 32'h0000_003F, 32'h3333_D003);
        finish_test("operand_forms", e);
    endtask

    initial begin : main
        valid = 1'b0;
        is_rep = 1'b0;
        dir_dec = 1'b0;
        size = size_byte;
        count = '0;
        addr1 = '0;
        addr2 = '0;
        op1_sel = '0;
        op2_sel = '0;
        foreach (regs[i]) regs[i] = '0;
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        reset_state();
        cold_read();
        rep_up();
        rep_down();
        rep_zero();
        operand_forms();
        $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== mem_stage.f ====
src/mem_stage_pkg.sv
src/mem_req_if.sv
src/rep_walker.sv
src/dcache_lite.sv
src/opswap.sv
src/mem_stage.sv
test/mem_stage_assertions.sv
test/tb_mem_stage.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mem_stage
FILELIST  ?= mem_stage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG) || \
	    ! grep -q "Simulation completed successfully" $(LOG); then \
	    echo "FAIL: see $(LOG)"; exit 1; \
	fi
	@echo "PASS"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
